//--- hw/flight_pkg.sv
/* Shared widths, Q12.4 fixed-point constants and gains. Gains are fixed at build time,
   and there is no runtime update path. */
package flight_pkg;

	// widths
	localparam int REC_WIDTH  = 8;
	localparam int RATE_WIDTH = 16;
	localparam int FRAC_BITS  = 4;
	localparam int PROD_WIDTH = 32;
	// error is one bit wider than a rate so setpoint minus gyro cannot wrap
	localparam int ERR_WIDTH  = RATE_WIDTH + 1;
	localparam int ACC_WIDTH  = 34;
	localparam int MIX_WIDTH  = 18;

	// axis slots inside the rate loop
	localparam int NUM_AXES = 3;
	localparam int AX_YAW   = 0;
	localparam int AX_PITCH = 1;
	localparam int AX_ROLL  = 2;

	// stick mapping
	localparam int MAP_SHIFT = 2;
	localparam logic signed [RATE_WIDTH-1:0] MAP_OFFSET = 16'sd500;

	// 16-bit saturation bounds
	localparam logic signed [RATE_WIDTH-1:0] RATE_SAT_MAX = 16'sh7fff;
	localparam logic signed [RATE_WIDTH-1:0] RATE_SAT_MIN = 16'sh8000;

	// rate limits in deg/s, Q12.4
	localparam logic signed [RATE_WIDTH-1:0] THROTTLE_MAX = 250 << FRAC_BITS;
	localparam logic signed [RATE_WIDTH-1:0] RATE_MAX     = 100 << FRAC_BITS;
	localparam logic signed [RATE_WIDTH-1:0] RATE_MIN     = -(100 << FRAC_BITS);

	// angle to rate scaling, value * mult >>> shift
	localparam logic signed [RATE_WIDTH-1:0] YAW_SCALE_MULT      = 16'sd48;
	localparam logic signed [RATE_WIDTH-1:0] PITCH_SCALE_MULT    = 16'sd40;
	localparam logic signed [RATE_WIDTH-1:0] ROLL_SCALE_MULT     = 16'sd40;
	localparam logic signed [RATE_WIDTH-1:0] THROTTLE_SCALE_MULT = 16'sd1;
	localparam int unsigned YAW_SCALE_SHIFT      = 4;
	localparam int unsigned PITCH_SCALE_SHIFT    = 4;
	localparam int unsigned ROLL_SCALE_SHIFT     = 4;
	localparam int unsigned THROTTLE_SCALE_SHIFT = 0;

	// rate loop gains, same on all axes
	localparam logic signed [RATE_WIDTH-1:0] KP_MULT = 16'sd24;
	localparam int unsigned KP_SHIFT = 4;
	localparam logic signed [RATE_WIDTH-1:0] KI_MULT = 16'sd8;
	localparam int unsigned KI_SHIFT = 6;
	localparam logic signed [RATE_WIDTH-1:0] INT_LIMIT = 200 << FRAC_BITS;

	// motor command range
	localparam logic signed [RATE_WIDTH-1:0] MOTOR_MIN = 16'sd0;
	localparam logic signed [RATE_WIDTH-1:0] MOTOR_MAX = 1000 << FRAC_BITS;

	typedef enum logic [2:0] {IDLE, MAP, SCALE, LIMIT, RATE, MIX, DONE} seq_state_t;

endpackage

//--- hw/flight_sequencer.sv
/* Walks the datapath phases once per start. Start is only looked at in IDLE, so a start
   during a run is dropped; done pulses for one cycle on the edge where busy falls. */
module flight_sequencer
	import flight_pkg::*;
(
	input  logic us_clk,
	input  logic resetn,
	input  logic start,
	output logic map_en,
	output logic scale_en,
	output logic limit_en,
	output logic rate_en,
	output logic mix_en,
	output logic busy,
	output logic done
);

	seq_state_t state;
	seq_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start)
					state_nxt = MAP;
			end
			MAP:     state_nxt = SCALE;
			SCALE:   state_nxt = LIMIT;
			LIMIT:   state_nxt = RATE;
			RATE:    state_nxt = MIX;
			MIX:     state_nxt = DONE;
			DONE:    state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// strobes trail the phase register by one cycle, glitch free
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			map_en   <= 1'b0;
			scale_en <= 1'b0;
			limit_en <= 1'b0;
			rate_en  <= 1'b0;
			mix_en   <= 1'b0;
			busy     <= 1'b0;
			done     <= 1'b0;
		end else begin
			map_en   <= (state == MAP);
			scale_en <= (state == SCALE);
			limit_en <= (state == LIMIT);
			rate_en  <= (state == RATE);
			mix_en   <= (state == MIX);
			busy     <= (state != IDLE);
			// falling edge of busy, motors have settled by now
			done     <= busy && (state == IDLE);
		end
	end

endmodule

//--- hw/angle_stage.sv
/* Angle to rate stage, one step per strobe. Mapping is 16-bit and wraps for extreme IMU
   angles; scaling saturates, then rates are clamped to the package limits. */
module angle_stage
	import flight_pkg::*;
(
	input  logic                         us_clk,
	input  logic                         resetn,
	input  logic                         map_en,
	input  logic                         scale_en,
	input  logic                         limit_en,
	input  logic [REC_WIDTH-1:0]         throttle_target,
	input  logic [REC_WIDTH-1:0]         pitch_target,
	input  logic [REC_WIDTH-1:0]         roll_target,
	input  logic signed [RATE_WIDTH-1:0] yaw_angle_error_in,
	input  logic signed [RATE_WIDTH-1:0] pitch_actual,
	input  logic signed [RATE_WIDTH-1:0] roll_actual,
	output logic signed [RATE_WIDTH-1:0] throttle_rate,
	output logic signed [RATE_WIDTH-1:0] yaw_rate_sp,
	output logic signed [RATE_WIDTH-1:0] pitch_rate_sp,
	output logic signed [RATE_WIDTH-1:0] roll_rate_sp,
	output logic signed [RATE_WIDTH-1:0] pitch_angle_error,
	output logic signed [RATE_WIDTH-1:0] roll_angle_error
);

	logic signed [RATE_WIDTH-1:0] mapped_throttle;
	logic signed [RATE_WIDTH-1:0] mapped_yaw;
	logic signed [RATE_WIDTH-1:0] mapped_pitch;
	logic signed [RATE_WIDTH-1:0] mapped_roll;
	logic signed [RATE_WIDTH-1:0] scaled_throttle;
	logic signed [RATE_WIDTH-1:0] scaled_yaw;
	logic signed [RATE_WIDTH-1:0] scaled_pitch;
	logic signed [RATE_WIDTH-1:0] scaled_roll;

	// (val * mult) >>> shift in 32 bits, saturated back to 16
	function automatic logic signed [RATE_WIDTH-1:0] scale_sat(
		input logic signed [RATE_WIDTH-1:0] val,
		input logic signed [RATE_WIDTH-1:0] mult,
		input int unsigned                  shift
	);
		logic signed [PROD_WIDTH-1:0] prod;
		prod = val * mult;
		prod = prod >>> shift;
		if (prod > RATE_SAT_MAX)
			return RATE_SAT_MAX;
		else if (prod < RATE_SAT_MIN)
			return RATE_SAT_MIN;
		else
			return prod[RATE_WIDTH-1:0];
	endfunction

	function automatic logic signed [RATE_WIDTH-1:0] clamp(
		input logic signed [RATE_WIDTH-1:0] val,
		input logic signed [RATE_WIDTH-1:0] lo,
		input logic signed [RATE_WIDTH-1:0] hi
	);
		if (val > hi)
			return hi;
		else if (val < lo)
			return lo;
		else
			return val;
	endfunction

	// map and scale payload, loaded on their strobes
	always_ff @(posedge us_clk) begin
		if (map_en) begin
			mapped_throttle <= $signed(RATE_WIDTH'(throttle_target) << FRAC_BITS);
			mapped_yaw      <= yaw_angle_error_in;
			mapped_pitch    <= $signed(RATE_WIDTH'(pitch_target) << MAP_SHIFT)
				- MAP_OFFSET - pitch_actual;
			// imu reports roll with the opposite sign
			mapped_roll     <= $signed(RATE_WIDTH'(roll_target) << MAP_SHIFT)
				- MAP_OFFSET + roll_actual;
		end
		if (scale_en) begin
			scaled_throttle <= scale_sat(mapped_throttle, THROTTLE_SCALE_MULT,
				THROTTLE_SCALE_SHIFT);
			scaled_yaw      <= scale_sat(mapped_yaw, YAW_SCALE_MULT, YAW_SCALE_SHIFT);
			scaled_pitch    <= scale_sat(mapped_pitch, PITCH_SCALE_MULT, PITCH_SCALE_SHIFT);
			scaled_roll     <= scale_sat(mapped_roll, ROLL_SCALE_MULT, ROLL_SCALE_SHIFT);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_rate     <= '0;
			yaw_rate_sp       <= '0;
			pitch_rate_sp     <= '0;
			roll_rate_sp      <= '0;
			pitch_angle_error <= '0;
			roll_angle_error  <= '0;
		end else if (limit_en) begin
			// throttle never goes negative
			throttle_rate     <= clamp(scaled_throttle, '0, THROTTLE_MAX);
			yaw_rate_sp       <= clamp(scaled_yaw, RATE_MIN, RATE_MAX);
			pitch_rate_sp     <= clamp(scaled_pitch, RATE_MIN, RATE_MAX);
			roll_rate_sp      <= clamp(scaled_roll, RATE_MIN, RATE_MAX);
			pitch_angle_error <= mapped_pitch;
			roll_angle_error  <= mapped_roll;
		end
	end

endmodule

//--- hw/rate_pid.sv
/* PI rate loop for yaw, pitch and roll with shared gains. Integrators hold across runs
   and clear only on reset; no derivative term. */
module rate_pid
	import flight_pkg::*;
(
	input  logic                         us_clk,
	input  logic                         resetn,
	input  logic                         rate_en,
	input  logic signed [RATE_WIDTH-1:0] yaw_rate_sp,
	input  logic signed [RATE_WIDTH-1:0] pitch_rate_sp,
	input  logic signed [RATE_WIDTH-1:0] roll_rate_sp,
	input  logic signed [RATE_WIDTH-1:0] yaw_gyro,
	input  logic signed [RATE_WIDTH-1:0] pitch_gyro,
	input  logic signed [RATE_WIDTH-1:0] roll_gyro,
	output logic signed [RATE_WIDTH-1:0] yaw_cmd,
	output logic signed [RATE_WIDTH-1:0] pitch_cmd,
	output logic signed [RATE_WIDTH-1:0] roll_cmd
);

	logic signed [ERR_WIDTH-1:0]  err       [NUM_AXES];
	logic signed [RATE_WIDTH-1:0] integ     [NUM_AXES];
	logic signed [RATE_WIDTH-1:0] integ_nxt [NUM_AXES];
	logic signed [RATE_WIDTH-1:0] cmd_nxt   [NUM_AXES];

	// integ + (err * ki) >>> shift, held inside +-INT_LIMIT
	function automatic logic signed [RATE_WIDTH-1:0] integ_step(
		input logic signed [RATE_WIDTH-1:0] acc_in,
		input logic signed [ERR_WIDTH-1:0]  e
	);
		logic signed [ACC_WIDTH-1:0] acc;
		acc = e * KI_MULT;
		acc = (acc >>> KI_SHIFT) + acc_in;
		if (acc > INT_LIMIT)
			return INT_LIMIT;
		else if (acc < -INT_LIMIT)
			return -INT_LIMIT;
		else
			return acc[RATE_WIDTH-1:0];
	endfunction

	// uses the integrator value written this same cycle
	function automatic logic signed [RATE_WIDTH-1:0] cmd_step(
		input logic signed [ERR_WIDTH-1:0]  e,
		input logic signed [RATE_WIDTH-1:0] i_term
	);
		logic signed [ACC_WIDTH-1:0] acc;
		acc = e * KP_MULT;
		acc = (acc >>> KP_SHIFT) + i_term;
		if (acc > RATE_SAT_MAX)
			return RATE_SAT_MAX;
		else if (acc < RATE_SAT_MIN)
			return RATE_SAT_MIN;
		else
			return acc[RATE_WIDTH-1:0];
	endfunction

	assign err[AX_YAW]   = yaw_rate_sp - yaw_gyro;
	assign err[AX_PITCH] = pitch_rate_sp - pitch_gyro;
	assign err[AX_ROLL]  = roll_rate_sp - roll_gyro;

	always_comb begin
		for (int i = 0; i < NUM_AXES; i++) begin
			integ_nxt[i] = integ_step(integ[i], err[i]);
			cmd_nxt[i]   = cmd_step(err[i], integ_nxt[i]);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < NUM_AXES; i++)
				integ[i] <= '0;
			yaw_cmd   <= '0;
			pitch_cmd <= '0;
			roll_cmd  <= '0;
		end else if (rate_en) begin
			for (int i = 0; i < NUM_AXES; i++)
				integ[i] <= integ_nxt[i];
			yaw_cmd   <= cmd_nxt[AX_YAW];
			pitch_cmd <= cmd_nxt[AX_PITCH];
			roll_cmd  <= cmd_nxt[AX_ROLL];
		end
	end

endmodule

//--- hw/motor_mixer.sv
/* X-frame mixer, motor 0 front right counting clockwise in the yaw sign used here.
   Sums are 18 bits wide and cannot overflow before the clamp. */
module motor_mixer
	import flight_pkg::*;
(
	input  logic                         us_clk,
	input  logic                         resetn,
	input  logic                         mix_en,
	input  logic signed [RATE_WIDTH-1:0] throttle_rate,
	input  logic signed [RATE_WIDTH-1:0] yaw_cmd,
	input  logic signed [RATE_WIDTH-1:0] pitch_cmd,
	input  logic signed [RATE_WIDTH-1:0] roll_cmd,
	output logic signed [RATE_WIDTH-1:0] motor_0,
	output logic signed [RATE_WIDTH-1:0] motor_1,
	output logic signed [RATE_WIDTH-1:0] motor_2,
	output logic signed [RATE_WIDTH-1:0] motor_3
);

	logic signed [MIX_WIDTH-1:0] sum_0;
	logic signed [MIX_WIDTH-1:0] sum_1;
	logic signed [MIX_WIDTH-1:0] sum_2;
	logic signed [MIX_WIDTH-1:0] sum_3;

	function automatic logic signed [RATE_WIDTH-1:0] motor_clamp(
		input logic signed [MIX_WIDTH-1:0] s
	);
		if (s > MOTOR_MAX)
			return MOTOR_MAX;
		else if (s < MOTOR_MIN)
			return MOTOR_MIN;
		else
			return s[RATE_WIDTH-1:0];
	endfunction

	// diagonal pairs spin the same way, so yaw alternates sign
	assign sum_0 = throttle_rate + pitch_cmd + roll_cmd - yaw_cmd;
	assign sum_1 = throttle_rate + pitch_cmd - roll_cmd + yaw_cmd;
	assign sum_2 = throttle_rate - pitch_cmd - roll_cmd - yaw_cmd;
	assign sum_3 = throttle_rate - pitch_cmd + roll_cmd + yaw_cmd;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_0 <= '0;
			motor_1 <= '0;
			motor_2 <= '0;
			motor_3 <= '0;
		end else if (mix_en) begin
			motor_0 <= motor_clamp(sum_0);
			motor_1 <= motor_clamp(sum_1);
			motor_2 <= motor_clamp(sum_2);
			motor_3 <= motor_clamp(sum_3);
		end
	end

endmodule

//--- hw/flight_ctrl_top.sv
/* Stick and IMU in, four motor commands out. Pulse start while idle and wait for done;
   a start during busy is ignored. */
module flight_ctrl_top
	import flight_pkg::*;
(
	input  logic                         us_clk,
	input  logic                         resetn,
	input  logic                         start,
	input  logic [REC_WIDTH-1:0]         throttle_target,
	input  logic [REC_WIDTH-1:0]         pitch_target,
	input  logic [REC_WIDTH-1:0]         roll_target,
	input  logic signed [RATE_WIDTH-1:0] yaw_angle_error_in,
	input  logic signed [RATE_WIDTH-1:0] pitch_actual,
	input  logic signed [RATE_WIDTH-1:0] roll_actual,
	input  logic signed [RATE_WIDTH-1:0] yaw_gyro,
	input  logic signed [RATE_WIDTH-1:0] pitch_gyro,
	input  logic signed [RATE_WIDTH-1:0] roll_gyro,
	output logic signed [RATE_WIDTH-1:0] motor_0,
	output logic signed [RATE_WIDTH-1:0] motor_1,
	output logic signed [RATE_WIDTH-1:0] motor_2,
	output logic signed [RATE_WIDTH-1:0] motor_3,
	output logic signed [RATE_WIDTH-1:0] pitch_angle_error,
	output logic signed [RATE_WIDTH-1:0] roll_angle_error,
	output logic                         busy,
	output logic                         done
);

	// phase strobes
	logic map_en;
	logic scale_en;
	logic limit_en;
	logic rate_en;
	logic mix_en;

	// limited setpoints and loop outputs
	logic signed [RATE_WIDTH-1:0] throttle_rate;
	logic signed [RATE_WIDTH-1:0] yaw_rate_sp;
	logic signed [RATE_WIDTH-1:0] pitch_rate_sp;
	logic signed [RATE_WIDTH-1:0] roll_rate_sp;
	logic signed [RATE_WIDTH-1:0] yaw_cmd;
	logic signed [RATE_WIDTH-1:0] pitch_cmd;
	logic signed [RATE_WIDTH-1:0] roll_cmd;

	flight_sequencer u_seq (
		.us_clk, .resetn, .start,
		.map_en, .scale_en, .limit_en, .rate_en, .mix_en,
		.busy, .done
	);

	angle_stage u_angle (
		.us_clk, .resetn, .map_en, .scale_en, .limit_en,
		.throttle_target, .pitch_target, .roll_target,
		.yaw_angle_error_in, .pitch_actual, .roll_actual,
		.throttle_rate, .yaw_rate_sp, .pitch_rate_sp, .roll_rate_sp,
		.pitch_angle_error, .roll_angle_error
	);

	rate_pid u_pid (
		.us_clk, .resetn, .rate_en,
		.yaw_rate_sp, .pitch_rate_sp, .roll_rate_sp,
		.yaw_gyro, .pitch_gyro, .roll_gyro,
		.yaw_cmd, .pitch_cmd, .roll_cmd
	);

	motor_mixer u_mix (
		.us_clk, .resetn, .mix_en,
		.throttle_rate, .yaw_cmd, .pitch_cmd, .roll_cmd,
		.motor_0, .motor_1, .motor_2, .motor_3
	);

endmodule

//--- bench/tb_clock_gen.sv
/* 100 ns us_clk; resetn is low for the first 10 cycles and whenever reset_req is high. */
module tb_clock_gen (
	input  logic reset_req,
	output logic us_clk,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 1ns;

	logic por_n;

	initial begin
		us_clk = 1'b0;
		forever #50 us_clk = ~us_clk;
	end

	initial begin
		por_n = 1'b0;
		repeat (10) @(posedge us_clk);
		por_n <= 1'b1;
	end

	assign resetn = por_n && !reset_req;

endmodule

//--- bench/flight_checker.sv
/* Reference model of the whole path, run once per done, plus a cycle check of busy and done.
   Inputs must be held from start until done. */
module flight_checker
	import flight_pkg::*;
(
	input logic                         us_clk,
	input logic                         resetn,
	input logic                         start,
	input logic [REC_WIDTH-1:0]         throttle_target,
	input logic [REC_WIDTH-1:0]         pitch_target,
	input logic [REC_WIDTH-1:0]         roll_target,
	input logic signed [RATE_WIDTH-1:0] yaw_angle_error_in,
	input logic signed [RATE_WIDTH-1:0] pitch_actual,
	input logic signed [RATE_WIDTH-1:0] roll_actual,
	input logic signed [RATE_WIDTH-1:0] yaw_gyro,
	input logic signed [RATE_WIDTH-1:0] pitch_gyro,
	input logic signed [RATE_WIDTH-1:0] roll_gyro,
	input logic signed [RATE_WIDTH-1:0] motor_0,
	input logic signed [RATE_WIDTH-1:0] motor_1,
	input logic signed [RATE_WIDTH-1:0] motor_2,
	input logic signed [RATE_WIDTH-1:0] motor_3,
	input logic signed [RATE_WIDTH-1:0] pitch_angle_error,
	input logic signed [RATE_WIDTH-1:0] roll_angle_error,
	input logic                         busy,
	input logic                         done
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam int KP = int'(KP_MULT);
	localparam int KI = int'(KI_MULT);
	localparam int ILIM = int'(INT_LIMIT);

	int error_count = 0;
	int check_count = 0;
	// edges since the sampled start, parked high while idle
	int cnt = 100;
	int k;
	int integ [3] = '{0, 0, 0};

	function automatic int limit_to(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	function automatic int wrap16(input int v);
		logic [15:0] t;
		t = v[15:0];
		return int'($signed(t));
	endfunction

	function automatic int scale_val(input int v, input int mult, input int unsigned sh);
		return limit_to((v * mult) >>> sh, -32768, 32767);
	endfunction

	task automatic compare(input string name, input int exp, input int act);
		check_count++;
		if (exp != act) begin
			error_count++;
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_run();
		int thr;
		int pm;
		int rm;
		int sp [3];
		int e;
		int cmd [3];
		int gyro [3];
		thr = int'(throttle_target) <<< FRAC_BITS;
		thr = scale_val(thr, int'(THROTTLE_SCALE_MULT), THROTTLE_SCALE_SHIFT);
		thr = limit_to(thr, 0, int'(THROTTLE_MAX));
		pm = wrap16((int'(pitch_target) <<< 2) - int'(MAP_OFFSET) - int'(pitch_actual));
		// roll sensor sign is inverted
		rm = wrap16((int'(roll_target) <<< 2) - int'(MAP_OFFSET) + int'(roll_actual));
		sp[0] = scale_val(int'(yaw_angle_error_in), int'(YAW_SCALE_MULT), YAW_SCALE_SHIFT);
		sp[1] = scale_val(pm, int'(PITCH_SCALE_MULT), PITCH_SCALE_SHIFT);
		sp[2] = scale_val(rm, int'(ROLL_SCALE_MULT), ROLL_SCALE_SHIFT);
		gyro[0] = int'(yaw_gyro);
		gyro[1] = int'(pitch_gyro);
		gyro[2] = int'(roll_gyro);
		for (int i = 0; i < 3; i++) begin
			sp[i] = limit_to(sp[i], int'(RATE_MIN), int'(RATE_MAX));
			e = sp[i] - gyro[i];
			integ[i] = limit_to(integ[i] + ((e * KI) >>> KI_SHIFT), -ILIM, ILIM);
			cmd[i] = limit_to(((e * KP) >>> KP_SHIFT) + integ[i], -32768, 32767);
		end
		// cmd index 0 yaw, 1 pitch, 2 roll
		compare("motor_0", limit_to(thr + cmd[1] + cmd[2] - cmd[0], 0, int'(MOTOR_MAX)),
			int'(motor_0));
		compare("motor_1", limit_to(thr + cmd[1] - cmd[2] + cmd[0], 0, int'(MOTOR_MAX)),
			int'(motor_1));
		compare("motor_2", limit_to(thr - cmd[1] - cmd[2] - cmd[0], 0, int'(MOTOR_MAX)),
			int'(motor_2));
		compare("motor_3", limit_to(thr - cmd[1] + cmd[2] + cmd[0], 0, int'(MOTOR_MAX)),
			int'(motor_3));
		compare("pitch_angle_error", pm, int'(pitch_angle_error));
		compare("roll_angle_error", rm, int'(roll_angle_error));
	endtask

	always @(posedge us_clk) begin
		if (!resetn) begin
			cnt = 100;
			integ = '{0, 0, 0};
			compare("motor_0", 0, int'(motor_0));
			compare("motor_1", 0, int'(motor_1));
			compare("motor_2", 0, int'(motor_2));
			compare("motor_3", 0, int'(motor_3));
			compare("pitch_angle_error", 0, int'(pitch_angle_error));
			compare("roll_angle_error", 0, int'(roll_angle_error));
			compare("busy", 0, int'(busy));
			compare("done", 0, int'(done));
		end else begin
			k = cnt + 1;
			compare("busy", (k >= 2 && k <= 7) ? 1 : 0, int'(busy));
			compare("done", (k == 8) ? 1 : 0, int'(done));
			if (k == 8)
				check_run();
			// sequencer is back in IDLE after six edges, so start counts from the seventh
			if (k >= 7 && start)
				cnt = 0;
			else
				cnt = (k > 100) ? 100 : k;
		end
	end

endmodule

//--- bench/tb_flight_ctrl.sv
/* Applies a table of stick, IMU and gyro rows, one run per row, and waits for done.
   A watchdog bounds the run at 12 cycles per row plus the reset time. */
module tb_flight_ctrl;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int MAX_ROWS = 40;

	logic        us_clk;
	logic        resetn;
	logic        reset_req;
	logic        start;
	logic [7:0]  throttle_target;
	logic [7:0]  pitch_target;
	logic [7:0]  roll_target;
	logic signed [15:0] yaw_angle_error_in;
	logic signed [15:0] pitch_actual;
	logic signed [15:0] roll_actual;
	logic signed [15:0] yaw_gyro;
	logic signed [15:0] pitch_gyro;
	logic signed [15:0] roll_gyro;
	logic signed [15:0] motor_0;
	logic signed [15:0] motor_1;
	logic signed [15:0] motor_2;
	logic signed [15:0] motor_3;
	logic signed [15:0] pitch_angle_error;
	logic signed [15:0] roll_angle_error;
	logic        busy;
	logic        done;

	// columns: throttle, pitch, roll sticks, yaw error, pitch and roll angle, three gyros
	int row_val [MAX_ROWS][9];
	bit row_rst [MAX_ROWS];
	bit row_extra [MAX_ROWS];
	int n_rows = 0;

	tb_clock_gen u_clk (.*);
	flight_ctrl_top u_dut (.*);
	flight_checker u_chk (.*);

	task automatic add_row(input int tt, input int pt, input int rt, input int ye,
		input int pa, input int ra, input int yg, input int pg, input int rg,
		input bit rst, input bit extra);
		row_val[n_rows] = '{tt, pt, rt, ye, pa, ra, yg, pg, rg};
		row_rst[n_rows] = rst;
		row_extra[n_rows] = extra;
		n_rows++;
	endtask

	function automatic int rand_gyro();
		return int'($urandom % 32'd2001) - 1000;
	endfunction

	initial begin
		#1;
		#(100 * (n_rows * 12 + 10));
		$display("watchdog expired before all table rows finished");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		reset_req = 1'b0;
		start = 1'b0;
		throttle_target = '0;
		pitch_target = '0;
		roll_target = '0;
		yaw_angle_error_in = '0;
		pitch_actual = '0;
		roll_actual = '0;
		yaw_gyro = '0;
		pitch_gyro = '0;
		roll_gyro = '0;
		void'($urandom(63));
		// centred sticks, level
		add_row(100, 125, 125, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(120, 130, 120, 0, 0, 0, 0, 0, 0, 0, 0);
		// extremes hit the rate and throttle limits
		add_row(255, 255, 0, 32000, -3000, 3000, 0, 0, 0, 0, 0);
		add_row(0, 0, 255, -32000, 3000, -3000, 0, 0, 0, 0, 0);
		// roll sign
		add_row(100, 125, 125, 0, 40, 40, 0, 0, 0, 0, 0);
		add_row(100, 140, 110, 0, 80, 80, 0, 0, 0, 0, 0);
		// constant pitch error winds the integrator up to its limit
		for (int i = 0; i < 11; i++)
			add_row(128, 255, 125, 0, 0, 0, 0, -1600, 0, i == 0, 0);
		add_row(128, 255, 125, 0, 0, 0, 0, -1600, 0, 1, 0);
		add_row(128, 255, 125, 0, 0, 0, 0, -1600, 0, 0, 0);
		// motor clamps at both ends
		add_row(0, 0, 0, 0, 0, 0, 0, 1600, 1600, 1, 0);
		add_row(255, 255, 255, -32000, -3000, 3000, 1600, -1600, -1600, 0, 0);
		// start pulse while busy
		add_row(150, 120, 130, 100, 10, -10, 50, -50, 20, 0, 1);
		for (int i = 0; i < 4; i++)
			add_row(140, 110 + i * 10, 140 - i * 10, 200, -20, 30,
				rand_gyro(), rand_gyro(), rand_gyro(), 0, 0);

		@(posedge resetn);
		for (int i = 0; i < n_rows; i++) begin
			if (row_rst[i]) begin
				@(posedge us_clk);
				reset_req <= 1'b1;
				repeat (2) @(posedge us_clk);
				reset_req <= 1'b0;
			end
			@(posedge us_clk);
			throttle_target <= 8'(row_val[i][0]);
			pitch_target <= 8'(row_val[i][1]);
			roll_target <= 8'(row_val[i][2]);
			yaw_angle_error_in <= 16'(row_val[i][3]);
			pitch_actual <= 16'(row_val[i][4]);
			roll_actual <= 16'(row_val[i][5]);
			yaw_gyro <= 16'(row_val[i][6]);
			pitch_gyro <= 16'(row_val[i][7]);
			roll_gyro <= 16'(row_val[i][8]);
			start <= 1'b1;
			@(posedge us_clk);
			start <= 1'b0;
			if (row_extra[i]) begin
				repeat (2) @(posedge us_clk);
				start <= 1'b1;
				@(posedge us_clk);
				start <= 1'b0;
			end
			do
				@(posedge us_clk);
			while (!done);
		end
		repeat (2) @(posedge us_clk);
		$display("checks: %0d errors: %0d", u_chk.check_count, u_chk.error_count);
		if (u_chk.error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- sim.f
hw/flight_pkg.sv
hw/flight_sequencer.sv
hw/angle_stage.sv
hw/rate_pid.sv
hw/motor_mixer.sv
hw/flight_ctrl_top.sv
bench/tb_clock_gen.sv
bench/flight_checker.sv
bench/tb_flight_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the flight controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_flight_ctrl -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0
